// File: verilog/fmSynth_settings.svh
// ####################################################################
// build-wide constants for the two-operator FM tone generator
// widths are tied together, so PCM_BITS 12 and ACCUM_BITS 16 move as a pair
// the device decode assumes a 32-bit byte address bus
// ####################################################################

`ifndef FMSYNTH_SETTINGS_SVH
`define FMSYNTH_SETTINGS_SVH

// channel rover, one channel per clock
`define CHANNELS 16
`define CHAN_BITS 4

// phase accumulator, table index taken from the top bits
`define PHASE_BITS 20

// operator sample and final output width
`define PCM_BITS 12

// mix accumulator, four bits of headroom over a sample
`define ACCUM_BITS 16

// device match on address bits 27..16
`define DEV_SELECT 12'h008

// channel block match on address bits 15..9
`define CHN_SELECT 7'h60

// bus response codes
`define BUS_OK_READY 2'd0
`define BUS_OK_OK 2'd1

`endif

// File: verilog/fmSynthPkg.sv
// ####################################################################
// types shared by the FM generator RTL and its testbench
// opControl layout is the register layout seen on the bus
// ####################################################################

`include "fmSynth_settings.svh"

package fmSynthPkg;

	// bus request as sampled by the device
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic rd;
		logic wr;
	} busReq;

	// bus response, two edges after the request edge
	typedef struct packed {
		logic [31:0] rdata;
		logic [1:0] ok;
	} busRsp;

	// one operator control word, msb first
	typedef struct packed {
		logic [3:0] shape;
		logic [2:0] volShift;
		logic [2:0] atten;
		logic reserved;
		// only meaningful in the carrier word
		logic fmEnable;
		logic [`PHASE_BITS-1:0] step;
	} opControl;

	// what one lane needs for one channel in one clock
	typedef struct packed {
		logic [`CHAN_BITS-1:0] chan;
		logic last;
		opControl ctrl;
		logic [`PHASE_BITS-1:0] phase;
	} chanContext;

	typedef logic signed [`PCM_BITS-1:0] opSample;

endpackage

// File: verilog/fmChannelSequencer.sv
// ####################################################################
// bus register bank, channel rover and phase store
// request sampled one edge late, response registered one edge after that
// phases advance at most once per frame, only in a step frame
// ####################################################################

`timescale 1ns/1ps
`include "fmSynth_settings.svh"

module fmChannelSequencer
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input busReq req,
	input logic sampleTick,
	output busRsp rsp,
	output chanContext modCtx,
	output chanContext carCtx
);

	localparam logic [`CHAN_BITS-1:0] chanLast = `CHAN_BITS'(`CHANNELS - 1);

	busReq reqQ;
	busRsp rspNext;
	logic devSel;
	logic chnSel;
	logic [`CHAN_BITS-1:0] regChan;
	logic [2:0] regSel;

	opControl carCtrl [`CHANNELS];
	opControl modCtrl [`CHANNELS];
	logic [`PHASE_BITS-1:0] carPhase [`CHANNELS];
	logic [`PHASE_BITS-1:0] modPhase [`CHANNELS];

	logic [`CHAN_BITS-1:0] rover;
	logic [`CHAN_BITS-1:0] roverLine [3];
	logic stepLine [3];
	logic tickLatch;
	logic stepFrame;

	// device and channel block decode on the registered request
	assign devSel = reqQ.addr[27:16] == `DEV_SELECT;
	assign chnSel = reqQ.addr[15:9] == `CHN_SELECT;
	assign regChan = reqQ.addr[8:5];
	assign regSel = reqQ.addr[4:2];

	always_comb
	begin
		rspNext.rdata = '0;
		rspNext.ok = `BUS_OK_READY;
		// any access to our device is acknowledged, even unmapped registers
		if (devSel && (reqQ.rd || reqQ.wr))
			rspNext.ok = `BUS_OK_OK;
		if (devSel && chnSel && reqQ.rd)
		begin
			case (regSel)
				3'd0: rspNext.rdata = carCtrl[regChan];
				3'd3: rspNext.rdata = 32'(carPhase[regChan]);
				3'd4: rspNext.rdata = modCtrl[regChan];
				3'd7: rspNext.rdata = 32'(modPhase[regChan]);
				default: rspNext.rdata = '0;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqQ <= '0;
			rsp.rdata <= '0;
			rsp.ok <= `BUS_OK_READY;
		end
		else
		begin
			reqQ <= req;
			rsp <= rspNext;
		end
	end

	// control writes, status registers are read only
	// phase update lands on the carrier issue slot, 3 clocks behind the rover
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `CHANNELS; i++)
			begin
				carCtrl[i] <= '0;
				modCtrl[i] <= '0;
				carPhase[i] <= '0;
				modPhase[i] <= '0;
			end
		end
		else
		begin
			if (devSel && chnSel && reqQ.wr && regSel == 3'd0)
				carCtrl[regChan] <= reqQ.wdata;
			if (devSel && chnSel && reqQ.wr && regSel == 3'd4)
				modCtrl[regChan] <= reqQ.wdata;
			if (stepLine[2])
			begin
				carPhase[roverLine[2]] <= carPhase[roverLine[2]] + carCtrl[roverLine[2]].step;
				modPhase[roverLine[2]] <= modPhase[roverLine[2]] + modCtrl[roverLine[2]].step;
			end
		end
	end

	// free rover, a pending tick turns the next frame into a step frame
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rover <= '0;
			tickLatch <= 1'b0;
			stepFrame <= 1'b0;
			roverLine <= '{default: '0};
			stepLine <= '{default: 1'b0};
		end
		else
		begin
			rover <= rover + 1'b1;
			if (rover == chanLast)
			begin
				stepFrame <= tickLatch;
				tickLatch <= sampleTick;
			end
			else if (sampleTick)
				tickLatch <= 1'b1;
			roverLine <= '{rover, roverLine[0], roverLine[1]};
			stepLine <= '{stepFrame, stepLine[0], stepLine[1]};
		end
	end

	// both contexts carry the phase before this frame's update
	always_comb
	begin
		modCtx.chan = rover;
		modCtx.last = rover == chanLast;
		modCtx.ctrl = modCtrl[rover];
		modCtx.phase = modPhase[rover];
		carCtx.chan = roverLine[2];
		carCtx.last = roverLine[2] == chanLast;
		carCtx.ctrl = carCtrl[roverLine[2]];
		carCtx.phase = carPhase[roverLine[2]];
	end

endmodule

// File: verilog/fmOperator.sv
// ####################################################################
// one operator lane, 3 clocks from ctx to smp
// modIn is only used with UseModulation set and fm enable on
// ####################################################################

`timescale 1ns/1ps

module fmOperator
	import fmSynthPkg::*;
#(
	parameter int UseModulation = 0
)
(
	input logic clock,
	input logic reset,
	input chanContext ctx,
	input opSample modIn,
	output opSample smp,
	output chanContext ctxOut
);

	// one full sine period, signed 8-bit
	localparam logic [7:0] sineTable [64] = '{
		8'h00, 8'h0C, 8'h18, 8'h24, 8'h30, 8'h3B, 8'h46, 8'h50,
		8'h59, 8'h62, 8'h69, 8'h70, 8'h75, 8'h79, 8'h7C, 8'h7E,
		8'h7F, 8'h7E, 8'h7C, 8'h79, 8'h75, 8'h70, 8'h69, 8'h62,
		8'h59, 8'h50, 8'h46, 8'h3B, 8'h30, 8'h24, 8'h18, 8'h0C,
		8'h00, 8'hF4, 8'hE8, 8'hDC, 8'hD0, 8'hC5, 8'hBA, 8'hB0,
		8'hA7, 8'h9E, 8'h97, 8'h90, 8'h8B, 8'h87, 8'h84, 8'h82,
		8'h81, 8'h82, 8'h84, 8'h87, 8'h8B, 8'h90, 8'h97, 8'h9E,
		8'hA7, 8'hB0, 8'hBA, 8'hC5, 8'hD0, 8'hDC, 8'hE8, 8'hF4
	};

	logic [5:0] fmOffset;
	logic [5:0] idxFull;
	logic [5:0] idxHalf;
	chanContext s1Ctx;
	logic [7:0] s1Full;
	logic [7:0] s1Half;
	logic [5:0] s1Idx;
	logic [7:0] shaped;
	logic [7:0] bias;
	chanContext s2Ctx;
	opSample s2Val;
	opSample attenVal;

	// phase modulation from the modulator output, bits 9..4
	assign fmOffset = (UseModulation != 0 && ctx.ctrl.fmEnable) ? modIn[9:4] : 6'd0;
	assign idxFull = ctx.phase[19:14] + fmOffset;
	// double-rate index for shapes 4 and 5
	assign idxHalf = ctx.phase[18:13] + fmOffset;

	// shape and its bias correction
	always_comb
	begin
		case (s1Ctx.ctrl.shape)
			4'h1: shaped = s1Full[7] ? 8'h00 : s1Full;
			4'h2: shaped = s1Full[7] ? ~s1Full : s1Full;
			4'h3: shaped = s1Ctx.phase[18] ? 8'h00 : s1Full;
			4'h4: shaped = s1Ctx.phase[18] ? 8'h00 : s1Half;
			4'h5: shaped = s1Ctx.phase[18] ? 8'h00 : (s1Half[7] ? ~s1Half : s1Half);
			// square
			4'h6: shaped = s1Full[7] ? 8'h80 : 8'h7F;
			// saw from the index itself
			4'h7: shaped = {s1Idx[5], ~s1Idx[4:0], ~s1Idx[5:4]};
			default: shaped = s1Full;
		endcase
		case (s1Ctx.ctrl.shape)
			4'h1, 4'h3, 4'h5: bias = 8'h28;
			4'h2: bias = 8'h50;
			default: bias = 8'h00;
		endcase
	end

	// attenuation taps are all taken from the unattenuated value
	always_comb
	begin
		attenVal = s2Val;
		if (s2Ctx.ctrl.atten[0])
			attenVal = attenVal - (s2Val >>> 3);
		if (s2Ctx.ctrl.atten[1])
			attenVal = attenVal - (s2Val >>> 2);
		if (s2Ctx.ctrl.atten[2])
			attenVal = attenVal - (s2Val >>> 1);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			s1Ctx <= '0;
			s1Full <= '0;
			s1Half <= '0;
			s1Idx <= '0;
			s2Ctx <= '0;
			s2Val <= '0;
			ctxOut <= '0;
			smp <= '0;
		end
		else
		begin
			s1Ctx <= ctx;
			s1Full <= sineTable[idxFull];
			s1Half <= sineTable[idxHalf];
			s1Idx <= idxFull;
			// widen by sign plus three zero bits
			s2Ctx <= s1Ctx;
			s2Val <= {shaped[7], shaped, 3'b000} - {1'b0, bias, 3'b000};
			ctxOut <= s2Ctx;
			smp <= attenVal >>> s2Ctx.ctrl.volShift;
		end
	end

endmodule

// File: verilog/fmVoiceMixer.sv
// ####################################################################
// channel mix, mute and frame output
// expects the carrier result with its own context, modulator 3 clocks earlier
// an add that would overflow the accumulator is dropped
// ####################################################################

`timescale 1ns/1ps
`include "fmSynth_settings.svh"

module fmVoiceMixer
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input opSample modSmp,
	input opSample carSmp,
	input chanContext carCtx,
	output logic [`PCM_BITS-1:0] outPcm
);

	opSample modDelay [3];
	logic signed [`ACCUM_BITS-1:0] chanVal;
	logic signed [`ACCUM_BITS-1:0] accum;
	logic signed [`ACCUM_BITS-1:0] base;
	logic signed [`ACCUM_BITS-1:0] sum;
	logic frameEndQ;
	logic [`PCM_BITS-1:0] pcmNext;

	// channel value, modulator only added in additive mode
	always_comb
	begin
		chanVal = carSmp;
		if (!carCtx.ctrl.fmEnable)
			chanVal = chanVal + modDelay[2];
		// silent channel, step too small to be heard
		if (carCtx.ctrl.step[19:8] == '0)
			chanVal = '0;
	end

	// first channel of a frame starts from zero
	always_comb
	begin
		base = frameEndQ ? '0 : accum;
		sum = base + chanVal;
		if ((base[`ACCUM_BITS-1] == chanVal[`ACCUM_BITS-1]) &&
			(sum[`ACCUM_BITS-1] != base[`ACCUM_BITS-1]))
			sum = base;
	end

	// saturate when the top bits are not a plain sign extension
	always_comb
	begin
		pcmNext = accum[`PCM_BITS:1];
		if ((accum[`ACCUM_BITS-1:`PCM_BITS] != '0) && (accum[`ACCUM_BITS-1:`PCM_BITS] != '1))
			pcmNext = accum[`ACCUM_BITS-1] ? {1'b1, {(`PCM_BITS-1){1'b0}}} :
				{1'b0, {(`PCM_BITS-1){1'b1}}};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			modDelay <= '{default: '0};
			accum <= '0;
			frameEndQ <= 1'b0;
			outPcm <= '0;
		end
		else
		begin
			// line up the modulator with the carrier result
			modDelay <= '{modSmp, modDelay[0], modDelay[1]};
			accum <= sum;
			frameEndQ <= carCtx.last;
			if (frameEndQ)
				outPcm <= pcmNext;
		end
	end

endmodule

// File: verilog/fmSynthTop.sv
// ####################################################################
// 16-channel two-operator FM tone generator, mono 12-bit PCM out
// sampleTick pulses must be at least 48 clocks apart
// outPcm updates once per 16-clock channel frame
// ####################################################################

`timescale 1ns/1ps
`include "fmSynth_settings.svh"

module fmSynthTop
	import fmSynthPkg::*;
(
	input logic clock,
	input logic reset,
	input busReq req,
	input logic sampleTick,
	output busRsp rsp,
	output logic [`PCM_BITS-1:0] outPcm
);

	chanContext modCtx;
	chanContext carCtx;
	chanContext carOutCtx;
	opSample modSmp;
	opSample carSmp;

	// register bank, rover and phase store
	fmChannelSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.req(req),
		.sampleTick(sampleTick),
		.rsp(rsp),
		.modCtx(modCtx),
		.carCtx(carCtx)
	);

	// modulator lane has no modulation input
	fmOperator #(.UseModulation(0)) modLane (
		.clock(clock),
		.reset(reset),
		.ctx(modCtx),
		.modIn('0),
		.smp(modSmp),
		.ctxOut()
	);

	// carrier lane, modulator sample arrives together with carCtx
	fmOperator #(.UseModulation(1)) carLane (
		.clock(clock),
		.reset(reset),
		.ctx(carCtx),
		.modIn(modSmp),
		.smp(carSmp),
		.ctxOut(carOutCtx)
	);

	fmVoiceMixer mixer (
		.clock(clock),
		.reset(reset),
		.modSmp(modSmp),
		.carSmp(carSmp),
		.carCtx(carOutCtx),
		.outPcm(outPcm)
	);

endmodule

// File: tb/fmSynthTb.sv
// ####################################################################
// directed testbench for the FM tone generator that stops at the first error
// output checks wait 48 clocks so the 8-clock mix latency has settled
// ticks are spaced 49 clocks apart to stay above the 48-clock minimum
// ####################################################################

`timescale 1ns/1ps
`include "fmSynth_settings.svh"

module fmSynthTb
	import fmSynthPkg::*;
();

	localparam int clockPeriod = 8;
	localparam int settleClocks = 48;
	// 200 us covers all directed tests with a wide margin
	localparam int watchdogTime = 200000;

	logic clock;
	logic reset;
	busReq req;
	logic sampleTick;
	busRsp rsp;
	logic [`PCM_BITS-1:0] outPcm;

	logic [31:0] rngState;
	// expected value of each channel in the mix
	int modelChan [`CHANNELS];

	fmSynthTop uut (
		.clock(clock),
		.reset(reset),
		.req(req),
		.sampleTick(sampleTick),
		.rsp(rsp),
		.outPcm(outPcm)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial
	begin
		#(watchdogTime);
		$display("watchdog expired, the tests did not finish in time");
		failRun();
	end

	task automatic failRun();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
			failRun();
		end
	endtask

	// xorshift32
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	// inputs change 1 ns after the edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	task automatic applyReset();
		reset = 1'b1;
		req = '0;
		sampleTick = 1'b0;
		for (int c = 0; c < `CHANNELS; c++)
			modelChan[c] = 0;
		waitCycles(3);
		reset = 1'b0;
	endtask

	task automatic pulseTick();
		sampleTick = 1'b1;
		waitCycles(1);
		sampleTick = 1'b0;
	endtask

	// request is held for one edge and the response is valid after the second edge
	task automatic busAccess(input logic [31:0] addr, input logic [31:0] data, input logic rd,
		input logic wr, output busRsp r);
		req.addr = addr;
		req.wdata = data;
		req.rd = rd;
		req.wr = wr;
		waitCycles(1);
		req = '0;
		waitCycles(1);
		r = rsp;
	endtask

	function automatic logic [31:0] regAddr(input int chan, input int regNum);
		return {4'h0, `DEV_SELECT, `CHN_SELECT, 4'(chan), 3'(regNum), 2'b00};
	endfunction

	task automatic writeReg(input int chan, input int regNum, input logic [31:0] data);
		busRsp r;
		busAccess(regAddr(chan, regNum), data, 1'b0, 1'b1, r);
		checkValue("write ok code", 32'(r.ok), 32'(`BUS_OK_OK));
	endtask

	task automatic readReg(input int chan, input int regNum, output logic [31:0] data);
		busRsp r;
		busAccess(regAddr(chan, regNum), '0, 1'b1, 1'b0, r);
		checkValue("read ok code", 32'(r.ok), 32'(`BUS_OK_OK));
		data = r.rdata;
	endtask

	function automatic opControl makeCtrl(input int shape, input int volShift, input int atten,
		input logic fm, input int step);
		opControl c;
		c = '0;
		c.shape = 4'(shape);
		c.volShift = 3'(volShift);
		c.atten = 3'(atten);
		c.fmEnable = fm;
		c.step = `PHASE_BITS'(step);
		return c;
	endfunction

	// table index from the top six phase bits
	function automatic int phaseIndex(input int phase);
		return (phase >> 14) & 'h3F;
	endfunction

	// FM offset is modulator output bits 9..4
	function automatic int fmIndex(input int sample);
		return ((sample & 'hFFF) >> 4) & 'h3F;
	endfunction

	// square operator output where entries past index 32 are the negative half of the sine
	function automatic int squareOut(input int idx, input int atten, input int volShift);
		int v;
		int a;
		v = ((idx % 64) > 32) ? -128 * 8 : 127 * 8;
		a = v;
		if ((atten & 1) != 0)
			a = a - (v >>> 3);
		if ((atten & 2) != 0)
			a = a - (v >>> 2);
		if ((atten & 4) != 0)
			a = a - (v >>> 1);
		return a >>> volShift;
	endfunction

	function automatic int channelValue(input opControl car, input int carOut, input int modOut);
		// muted when the step is below 0x100
		if (car.step[`PHASE_BITS-1:8] == '0)
			return 0;
		if (car.fmEnable)
			return carOut;
		return carOut + modOut;
	endfunction

	// 16-bit sum with overflow hold followed by 12-bit saturation
	function automatic int modelPcm();
		int acc;
		int s;
		acc = 0;
		for (int c = 0; c < `CHANNELS; c++)
		begin
			s = acc + modelChan[c];
			if (s <= 32767 && s >= -32768)
				acc = s;
		end
		if (acc > 4095)
			return 'h7FF;
		if (acc < -4096)
			return 'h800;
		return (acc >>> 1) & 'hFFF;
	endfunction

	task automatic checkOutput(input string what, input int exp);
		waitCycles(settleClocks);
		checkValue(what, 32'(outPcm), 32'(exp & 'hFFF));
	endtask

	task automatic testResetState();
		logic [31:0] data;
		applyReset();
		checkValue("outPcm after reset", 32'(outPcm), 0);
		for (int c = 0; c < `CHANNELS; c++)
		begin
			readReg(c, 3, data);
			checkValue("carrier phase after reset", data, 0);
			readReg(c, 7, data);
			checkValue("modulator phase after reset", data, 0);
		end
	endtask

	task automatic testRegisterAccess();
		logic [31:0] carShadow [`CHANNELS];
		logic [31:0] modShadow [`CHANNELS];
		logic [31:0] pick;
		logic [31:0] data;
		busRsp r;
		int chan;
		applyReset();
		for (int c = 0; c < `CHANNELS; c++)
		begin
			carShadow[c] = '0;
			modShadow[c] = '0;
		end
		repeat (40)
		begin
			pick = nextRandom();
			chan = pick[3:0];
			data = nextRandom();
			writeReg(chan, pick[4] ? 4 : 0, data);
			if (pick[4])
				modShadow[chan] = data;
			else
				carShadow[chan] = data;
		end
		for (int c = 0; c < `CHANNELS; c++)
		begin
			readReg(c, 0, data);
			checkValue("carrier control readback", data, carShadow[c]);
			readReg(c, 4, data);
			checkValue("modulator control readback", data, modShadow[c]);
		end
		// status registers ignore writes and phases stay 0 without a tick
		repeat (8)
		begin
			pick = nextRandom();
			chan = pick[3:0];
			writeReg(chan, pick[4] ? 7 : 3, nextRandom());
			readReg(chan, pick[4] ? 7 : 3, data);
			checkValue("status after write", data, 0);
		end
		// channel 2 carrier holds a nonzero word that a foreign read must not return
		writeReg(2, 0, 32'h5A5A_5A5A);
		// another device on the bus
		busAccess(regAddr(2, 0) ^ 32'h0001_0000, '0, 1'b1, 1'b0, r);
		checkValue("foreign ok code", 32'(r.ok), 32'(`BUS_OK_READY));
		checkValue("foreign rdata", r.rdata, 0);
	endtask

	task automatic testPhaseStep();
		opControl carCtl [`CHANNELS];
		opControl modCtl [`CHANNELS];
		logic [31:0] data;
		int ticks;
		ticks = 5;
		applyReset();
		for (int c = 0; c < `CHANNELS; c++)
		begin
			carCtl[c] = nextRandom();
			modCtl[c] = nextRandom();
			writeReg(c, 0, carCtl[c]);
			writeReg(c, 4, modCtl[c]);
		end
		repeat (ticks)
		begin
			pulseTick();
			waitCycles(settleClocks);
		end
		for (int c = 0; c < `CHANNELS; c++)
		begin
			readReg(c, 3, data);
			checkValue("carrier phase", data, 32'((ticks * int'(carCtl[c].step)) % (1 << 20)));
			readReg(c, 7, data);
			checkValue("modulator phase", data, 32'((ticks * int'(modCtl[c].step)) % (1 << 20)));
		end
	endtask

	task automatic testSquareMix();
		opControl car;
		opControl mod;
		int chan;
		chan = 5;
		applyReset();
		// both phases sit at 0 without ticks
		car = makeCtrl(6, 0, 0, 1'b0, 'h100);
		mod = makeCtrl(6, 0, 0, 1'b0, 'h100);
		writeReg(chan, 0, car);
		writeReg(chan, 4, mod);
		modelChan[chan] = channelValue(car, squareOut(0, 0, 0), squareOut(0, 0, 0));
		checkOutput("square pair", modelPcm());
		// sine at index 0 is zero so a cleared modulator adds nothing
		writeReg(chan, 4, '0);
		modelChan[chan] = channelValue(car, squareOut(0, 0, 0), 0);
		checkOutput("carrier only", modelPcm());
		car = makeCtrl(6, 1, 0, 1'b0, 'h100);
		writeReg(chan, 0, car);
		modelChan[chan] = channelValue(car, squareOut(0, 0, 1), 0);
		checkOutput("volume shift 1", modelPcm());
		car = makeCtrl(6, 0, 4, 1'b0, 'h100);
		writeReg(chan, 0, car);
		modelChan[chan] = channelValue(car, squareOut(0, 4, 0), 0);
		checkOutput("attenuation bit 2", modelPcm());
		car = makeCtrl(6, 0, 0, 1'b0, 'hFF);
		writeReg(chan, 0, car);
		modelChan[chan] = channelValue(car, squareOut(0, 0, 0), 0);
		checkOutput("muted channel", modelPcm());
	endtask

	task automatic testFullScale();
		opControl car;
		applyReset();
		car = makeCtrl(6, 0, 0, 1'b0, 'h84000);
		for (int c = 0; c < `CHANNELS; c++)
		begin
			writeReg(c, 0, car);
			modelChan[c] = channelValue(car, squareOut(0, 0, 0), 0);
		end
		checkOutput("all channels positive", modelPcm());
		// one step moves every carrier to the negative half
		pulseTick();
		waitCycles(settleClocks);
		for (int c = 0; c < `CHANNELS; c++)
			modelChan[c] = channelValue(car, squareOut(phaseIndex('h84000), 0, 0), 0);
		checkOutput("all channels negative", modelPcm());
	endtask

	task automatic testFmMode();
		opControl car;
		opControl mod;
		int modOut;
		int chan;
		chan = 9;
		applyReset();
		mod = makeCtrl(6, 0, 0, 1'b0, 'h100);
		car = makeCtrl(6, 0, 0, 1'b1, 'h100);
		writeReg(chan, 4, mod);
		writeReg(chan, 0, car);
		modOut = squareOut(0, 0, 0);
		modelChan[chan] = channelValue(car, squareOut(fmIndex(modOut), 0, 0), modOut);
		checkOutput("fm square", modelPcm());
	endtask

	initial
	begin
		rngState = 32'hfb00_e696;
		reset = 1'b1;
		req = '0;
		sampleTick = 1'b0;
		@(posedge clock);
		#1;
		testResetState();
		testRegisterAccess();
		testPhaseStep();
		testSquareMix();
		testFullScale();
		testFmMode();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: build.f
+incdir+verilog
verilog/fmSynthPkg.sv
verilog/fmChannelSequencer.sv
verilog/fmOperator.sv
verilog/fmVoiceMixer.sv
verilog/fmSynthTop.sv
tb/fmSynthTb.sv
